// ==== verilog/rv_core_pkg.sv ====
/* Core widths, opcodes, access sizes, ALU and forwarding codes,
   reset PC, NOP and the instruction-format union */
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0]    PC_START = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [INSTR_W-1:0] NOP      = 32'h0000_0013;

    // Major opcodes of the kept subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // Access size in funct3, same for loads and stores
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // ALU operation class, zero for anything that only adds
    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_CLS_ADD = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_CLS_REG = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_CLS_IMM = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_CLS_LUI = 4'd3;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

    // Operand source in execute
    localparam logic [1:0] FWD_NONE = 2'd0;
    localparam logic [1:0] FWD_MEM  = 2'd1;
    localparam logic [1:0] FWD_WB   = 2'd2;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One instruction word, four field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } instr_u;

endpackage

`default_nettype wire

// ==== verilog/rv_decode.sv ====
/* Instruction decoder: control bits and sign-extended immediate */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire rv_core_pkg::instr_u                i_instr,
    output logic [rv_core_pkg::ALU_OP_W-1:0]        o_alu_cls,
    output logic                                    o_use_imm,
    output logic                                    o_reg_w,
    output logic                                    o_is_load,
    output logic                                    o_is_store,
    output logic [rv_core_pkg::XLEN-1:0]            o_imm
);

    logic                        writes_rd;
    logic [rv_core_pkg::XLEN-1:0] imm_i;
    logic [rv_core_pkg::XLEN-1:0] imm_s;
    logic [rv_core_pkg::XLEN-1:0] imm_u;

    // Immediates of each format, sign bit is always instr[31]
    assign imm_i = {{(rv_core_pkg::XLEN-12){i_instr.i.imm[11]}}, i_instr.i.imm};
    assign imm_s = {{(rv_core_pkg::XLEN-12){i_instr.s.imm_hi[6]}},
                    i_instr.s.imm_hi, i_instr.s.imm_lo};
    assign imm_u = {i_instr.u.imm, 12'h000};

    always_comb begin
        o_alu_cls  = rv_core_pkg::ALU_CLS_ADD;
        o_use_imm  = 1'b0;
        writes_rd  = 1'b0;
        o_is_load  = 1'b0;
        o_is_store = 1'b0;
        o_imm      = '0;
        case (i_instr.r.opcode)
            rv_core_pkg::OPC_OP: begin
                o_alu_cls = rv_core_pkg::ALU_CLS_REG;
                writes_rd = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                o_alu_cls = rv_core_pkg::ALU_CLS_IMM;
                o_use_imm = 1'b1;
                writes_rd = 1'b1;
                o_imm     = imm_i;
            end
            rv_core_pkg::OPC_LOAD: begin
                o_use_imm = 1'b1;
                writes_rd = 1'b1;
                o_is_load = 1'b1;
                o_imm     = imm_i;
            end
            rv_core_pkg::OPC_STORE: begin
                o_use_imm  = 1'b1;
                o_is_store = 1'b1;
                o_imm      = imm_s;
            end
            rv_core_pkg::OPC_LUI: begin
                o_alu_cls = rv_core_pkg::ALU_CLS_LUI;
                o_use_imm = 1'b1;
                writes_rd = 1'b1;
                o_imm     = imm_u;
            end
            // Everything else behaves as a NOP
            default: ;
        endcase
    end

    // Writes to x0 are dropped here, so later stages never see them
    assign o_reg_w = writes_rd && (i_instr.r.rd != '0);

endmodule

`default_nettype wire

// ==== verilog/rv_regfile.sv ====
/* Register file, synchronous read with writeback bypass, x0 reads zero */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire                                   i_clk,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0]    i_rs1_addr,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0]    i_rs2_addr,
    input  wire                                   i_wr_en,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0]    i_rd_addr,
    input  wire  [rv_core_pkg::XLEN-1:0]          i_rd_data,
    output logic [rv_core_pkg::XLEN-1:0]          o_rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]          o_rs2_data
);

    logic [rv_core_pkg::XLEN-1:0]       regs [0:(2**rv_core_pkg::REG_ADDR_W)-1];
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_q;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_q;

    always_ff @(posedge i_clk) begin
        rs1_q <= i_rs1_addr;
        rs2_q <= i_rs2_addr;
        if (i_wr_en) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // A write in the read cycle wins over the array
    assign o_rs1_data = (rs1_q == '0)                      ? '0        :
                        (i_wr_en && (i_rd_addr == rs1_q))  ? i_rd_data : regs[rs1_q];
    assign o_rs2_data = (rs2_q == '0)                      ? '0        :
                        (i_wr_en && (i_rd_addr == rs2_q))  ? i_rd_data : regs[rs2_q];

    // Decode drops rd == x0, so no write to x0 reaches here
    a_no_x0_write: assert property (@(posedge i_clk) i_wr_en |-> (i_rd_addr != '0));

endmodule

`default_nettype wire

// ==== verilog/rv_alu.sv ====
/* ALU operation select from class and funct fields, and the ALU itself */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire  [rv_core_pkg::ALU_OP_W-1:0] i_alu_cls,
    input  wire  [2:0]                       i_funct3,
    input  wire  [6:0]                       i_funct7,
    input  wire  [rv_core_pkg::XLEN-1:0]     i_a,
    input  wire  [rv_core_pkg::XLEN-1:0]     i_b,
    output logic [rv_core_pkg::XLEN-1:0]     o_result
);

    logic [rv_core_pkg::ALU_OP_W-1:0] op;
    logic                             is_reg;
    logic [4:0]                       shamt;

    assign is_reg = (i_alu_cls == rv_core_pkg::ALU_CLS_REG);
    assign shamt  = i_b[4:0];

    always_comb begin
        op = rv_core_pkg::ALU_ADD;
        if (i_alu_cls == rv_core_pkg::ALU_CLS_LUI) begin
            op = rv_core_pkg::ALU_PASS_B;
        end else if (is_reg || (i_alu_cls == rv_core_pkg::ALU_CLS_IMM)) begin
            case (i_funct3)
                // ADDI has no SUB form, its bit 30 is immediate
                3'b000:  op = (is_reg && i_funct7[5]) ? rv_core_pkg::ALU_SUB
                                                      : rv_core_pkg::ALU_ADD;
                3'b001:  op = rv_core_pkg::ALU_SLL;
                3'b010:  op = rv_core_pkg::ALU_SLT;
                3'b011:  op = rv_core_pkg::ALU_SLTU;
                3'b100:  op = rv_core_pkg::ALU_XOR;
                3'b101:  op = i_funct7[5] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
                3'b110:  op = rv_core_pkg::ALU_OR;
                default: op = rv_core_pkg::ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (op)
            rv_core_pkg::ALU_SUB:    o_result = i_a - i_b;
            rv_core_pkg::ALU_AND:    o_result = i_a & i_b;
            rv_core_pkg::ALU_OR:     o_result = i_a | i_b;
            rv_core_pkg::ALU_XOR:    o_result = i_a ^ i_b;
            rv_core_pkg::ALU_SLT:    o_result = {{(rv_core_pkg::XLEN-1){1'b0}},
                                                 $signed(i_a) < $signed(i_b)};
            rv_core_pkg::ALU_SLTU:   o_result = {{(rv_core_pkg::XLEN-1){1'b0}}, i_a < i_b};
            rv_core_pkg::ALU_SLL:    o_result = i_a << shamt;
            rv_core_pkg::ALU_SRL:    o_result = i_a >> shamt;
            rv_core_pkg::ALU_SRA:    o_result = $unsigned($signed(i_a) >>> shamt);
            rv_core_pkg::ALU_PASS_B: o_result = i_b;
            default:                 o_result = i_a + i_b;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rv_hazard.sv ====
/* Forwarding selects, load-use bubble and stall control */
`timescale 1ns/1ps
`default_nettype none

module rv_hazard (
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_dec_rs1,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_dec_rs2,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_ex_rs1,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_ex_rs2,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_ex_rd,
    input  wire                                i_ex_is_load,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_mem_rd,
    input  wire                                i_mem_reg_w,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  wire                                i_wb_reg_w,
    input  wire                                i_if_valid,
    input  wire                                i_mem_load,
    input  wire                                i_mem_valid,
    output logic [1:0]                         o_fwd_a,
    output logic [1:0]                         o_fwd_b,
    output logic                               o_fetch_stall,
    output logic                               o_pipe_stall,
    output logic                               o_ex_bubble,
    output logic                               o_wb_bubble
);

    logic load_use;
    logic load_wait;

    // Youngest producer wins
    assign o_fwd_a = (i_mem_reg_w && (i_mem_rd == i_ex_rs1)) ? rv_core_pkg::FWD_MEM :
                     (i_wb_reg_w  && (i_wb_rd  == i_ex_rs1)) ? rv_core_pkg::FWD_WB  :
                                                               rv_core_pkg::FWD_NONE;
    assign o_fwd_b = (i_mem_reg_w && (i_mem_rd == i_ex_rs2)) ? rv_core_pkg::FWD_MEM :
                     (i_wb_reg_w  && (i_wb_rd  == i_ex_rs2)) ? rv_core_pkg::FWD_WB  :
                                                               rv_core_pkg::FWD_NONE;

    // Load data only exists from writeback on
    assign load_use  = i_ex_is_load && (i_ex_rd != '0) &&
                       ((i_ex_rd == i_dec_rs1) || (i_ex_rd == i_dec_rs2));
    assign load_wait = i_mem_load && !i_mem_valid;

    assign o_pipe_stall  = load_wait;
    assign o_wb_bubble   = load_wait;
    // Bubble waits until a held execute stage is released
    assign o_ex_bubble   = load_use && !load_wait;
    assign o_fetch_stall = !i_if_valid || load_use || load_wait;

endmodule

`default_nettype wire

// ==== verilog/rv_lsu.sv ====
/* Store data formatting and load data extension by access size */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
    input  wire  [2:0]                   i_funct3,
    input  wire  [rv_core_pkg::XLEN-1:0] i_store_src,
    input  wire  [rv_core_pkg::XLEN-1:0] i_load_raw,
    output logic [rv_core_pkg::XLEN-1:0] o_store_data,
    output logic [rv_core_pkg::XLEN-1:0] o_load_data
);

    localparam int XLEN = rv_core_pkg::XLEN;

    // Unused upper bytes go out as zero
    always_comb begin
        case (i_funct3)
            rv_core_pkg::F3_B,
            rv_core_pkg::F3_BU: o_store_data = {{(XLEN-8){1'b0}}, i_store_src[7:0]};
            rv_core_pkg::F3_H,
            rv_core_pkg::F3_HU: o_store_data = {{(XLEN-16){1'b0}}, i_store_src[15:0]};
            default:            o_store_data = i_store_src;
        endcase
    end

    // Byte and half loads extend the low part of the returned word
    always_comb begin
        case (i_funct3)
            rv_core_pkg::F3_B:  o_load_data = {{(XLEN-8){i_load_raw[7]}}, i_load_raw[7:0]};
            rv_core_pkg::F3_H:  o_load_data = {{(XLEN-16){i_load_raw[15]}}, i_load_raw[15:0]};
            rv_core_pkg::F3_BU: o_load_data = {{(XLEN-8){1'b0}}, i_load_raw[7:0]};
            rv_core_pkg::F3_HU: o_load_data = {{(XLEN-16){1'b0}}, i_load_raw[15:0]};
            default:            o_load_data = i_load_raw;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
/* Four-stage RV32I core top: PC, pipeline registers, operand muxes
   and the decode, register file, ALU, hazard and load/store instances */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                                 i_clk,
    input  wire                                 i_rst_n,
    input  wire                                 i_if_valid,
    input  wire  [rv_core_pkg::INSTR_W-1:0]     i_instr,
    output logic [rv_core_pkg::XLEN-1:0]        o_pc,
    output logic                                o_load_req,
    output logic                                o_store_req,
    output logic [rv_core_pkg::XLEN-1:0]        o_mem_addr,
    output logic [rv_core_pkg::XLEN-1:0]        o_mem_wdata,
    input  wire                                 i_mem_valid,
    input  wire  [rv_core_pkg::XLEN-1:0]        i_mem_rdata
);

    localparam int XLEN = rv_core_pkg::XLEN;
    localparam int RAW  = rv_core_pkg::REG_ADDR_W;

    rv_core_pkg::instr_u               if_instr;
    rv_core_pkg::instr_u               dec_instr;
    logic [XLEN-1:0]                   pc;
    logic [rv_core_pkg::ALU_OP_W-1:0]  dec_alu_cls;
    logic                              dec_use_imm, dec_reg_w, dec_is_load, dec_is_store;
    logic [XLEN-1:0]                   dec_imm;
    logic [RAW-1:0]                    rf_rs1_addr, rf_rs2_addr;
    logic [XLEN-1:0]                   rf_rs1_data, rf_rs2_data;

    // Execute stage
    logic [rv_core_pkg::ALU_OP_W-1:0]  ex_alu_cls;
    logic                              ex_use_imm, ex_reg_w, ex_is_load, ex_is_store;
    logic [2:0]                        ex_funct3;
    logic [6:0]                        ex_funct7;
    logic [RAW-1:0]                    ex_rs1, ex_rs2, ex_rd;
    logic [XLEN-1:0]                   ex_imm, ex_a, ex_b;
    logic [1:0]                        fwd_a, fwd_b;
    logic [XLEN-1:0]                   op_a, op_b, alu_b, alu_result;

    // Memory and writeback stages
    logic                              mem_reg_w, mem_is_load, mem_is_store;
    logic [2:0]                        mem_funct3;
    logic [RAW-1:0]                    mem_rd, wb_rd;
    logic [XLEN-1:0]                   mem_alu, mem_store_src, load_data, wb_data;
    logic                              wb_reg_w;
    logic                              fetch_stall, pipe_stall, ex_bubble, wb_bubble;

    assign if_instr = i_instr;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc        <= rv_core_pkg::PC_START;
            dec_instr <= rv_core_pkg::NOP;
        end else begin
            if (!fetch_stall) begin
                pc <= pc + XLEN'(4);
            end
            // Held instruction survives an invalid fetch cycle
            if (!(ex_bubble || pipe_stall)) begin
                dec_instr <= i_if_valid ? if_instr : rv_core_pkg::NOP;
            end
        end
    end

    // Re-read the held instruction so late writes are seen
    assign rf_rs1_addr = fetch_stall ? dec_instr.r.rs1 : if_instr.r.rs1;
    assign rf_rs2_addr = fetch_stall ? dec_instr.r.rs2 : if_instr.r.rs2;

    rv_decode u_decode (
        .i_instr    (dec_instr),
        .o_alu_cls  (dec_alu_cls),
        .o_use_imm  (dec_use_imm),
        .o_reg_w    (dec_reg_w),
        .o_is_load  (dec_is_load),
        .o_is_store (dec_is_store),
        .o_imm      (dec_imm)
    );

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rs1_addr (rf_rs1_addr),
        .i_rs2_addr (rf_rs2_addr),
        .i_wr_en    (wb_reg_w),
        .i_rd_addr  (wb_rd),
        .i_rd_data  (wb_data),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data)
    );

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || ex_bubble) begin
            ex_reg_w    <= 1'b0;
            ex_is_load  <= 1'b0;
            ex_is_store <= 1'b0;
        end else if (!pipe_stall) begin
            ex_reg_w    <= dec_reg_w;
            ex_is_load  <= dec_is_load;
            ex_is_store <= dec_is_store;
        end
    end

    always_ff @(posedge i_clk) begin
        if (pipe_stall) begin
            // Capture forwarded values, their producers move on meanwhile
            ex_a <= op_a;
            ex_b <= op_b;
        end else begin
            ex_alu_cls <= dec_alu_cls;
            ex_use_imm <= dec_use_imm;
            ex_funct3  <= dec_instr.r.funct3;
            ex_funct7  <= dec_instr.r.funct7;
            ex_rs1     <= dec_instr.r.rs1;
            ex_rs2     <= dec_instr.r.rs2;
            ex_rd      <= dec_instr.r.rd;
            ex_imm     <= dec_imm;
            ex_a       <= rf_rs1_data;
            ex_b       <= rf_rs2_data;
        end
    end

    assign op_a  = (fwd_a == rv_core_pkg::FWD_MEM) ? mem_alu :
                   (fwd_a == rv_core_pkg::FWD_WB)  ? wb_data : ex_a;
    assign op_b  = (fwd_b == rv_core_pkg::FWD_MEM) ? mem_alu :
                   (fwd_b == rv_core_pkg::FWD_WB)  ? wb_data : ex_b;
    assign alu_b = ex_use_imm ? ex_imm : op_b;

    rv_alu u_alu (
        .i_alu_cls (ex_alu_cls),
        .i_funct3  (ex_funct3),
        .i_funct7  (ex_funct7),
        .i_a       (op_a),
        .i_b       (alu_b),
        .o_result  (alu_result)
    );

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            mem_reg_w    <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
        end else if (!pipe_stall) begin
            mem_reg_w    <= ex_reg_w;
            mem_is_load  <= ex_is_load;
            mem_is_store <= ex_is_store;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!pipe_stall) begin
            mem_alu       <= alu_result;
            mem_store_src <= op_b;
            mem_funct3    <= ex_funct3;
            mem_rd        <= ex_rd;
        end
    end

    rv_lsu u_lsu (
        .i_funct3     (mem_funct3),
        .i_store_src  (mem_store_src),
        .i_load_raw   (i_mem_rdata),
        .o_store_data (o_mem_wdata),
        .o_load_data  (load_data)
    );

    // Writeback result chosen on entry
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || wb_bubble) begin
            wb_reg_w <= 1'b0;
        end else begin
            wb_reg_w <= mem_reg_w;
        end
        wb_rd   <= mem_rd;
        wb_data <= mem_is_load ? load_data : mem_alu;
    end

    rv_hazard u_hazard (
        .i_dec_rs1     (dec_instr.r.rs1),
        .i_dec_rs2     (dec_instr.r.rs2),
        .i_ex_rs1      (ex_rs1),
        .i_ex_rs2      (ex_rs2),
        .i_ex_rd       (ex_rd),
        .i_ex_is_load  (ex_is_load),
        .i_mem_rd      (mem_rd),
        .i_mem_reg_w   (mem_reg_w),
        .i_wb_rd       (wb_rd),
        .i_wb_reg_w    (wb_reg_w),
        .i_if_valid    (i_if_valid),
        .i_mem_load    (mem_is_load),
        .i_mem_valid   (i_mem_valid),
        .o_fwd_a       (fwd_a),
        .o_fwd_b       (fwd_b),
        .o_fetch_stall (fetch_stall),
        .o_pipe_stall  (pipe_stall),
        .o_ex_bubble   (ex_bubble),
        .o_wb_bubble   (wb_bubble)
    );

    assign o_pc        = pc;
    assign o_mem_addr  = mem_alu;
    assign o_load_req  = mem_is_load;
    assign o_store_req = mem_is_store;

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_pc[1:0] == 2'b00);
    a_one_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_load_req && o_store_req));

endmodule

`default_nettype wire

// ==== tb/rv_iss.svh ====
/* Instruction-level reference model of the kept RV32I subset and the
   data memory fill pattern, fills the expected store and load queues */
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

logic [31:0] ref_regs [0:31];
logic [31:0] ref_mem  [0:DMEM_WORDS-1];

// Initial data word, a function of the whole word index
function automatic logic [31:0] fill_word(input int idx);
    return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
endfunction

function automatic void write_reg(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
        ref_regs[rd] = value;
    end
endfunction

function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    logic [4:0]         sh;
    sa = a;
    sh = b[4:0];
    case (f3)
        3'b000:  return alt ? (a - b) : (a + b);
        3'b001:  return a << sh;
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101: begin
            if (alt) begin
                return sa >>> sh;
            end
            return a >> sh;
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// Executes the whole program in order, one instruction at a time
task automatic run_reference();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] imm_i;
    logic [2:0]  f3;
    for (int r = 0; r < 32; r++) begin
        ref_regs[r] = 32'd0;
    end
    for (int w = 0; w < DMEM_WORDS; w++) begin
        ref_mem[w] = fill_word(w);
    end
    for (int pc = 0; pc < PROG_LEN; pc++) begin
        ins   = prog[pc];
        f3    = ins[14:12];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        case (ins[6:0])
            rv_core_pkg::OPC_OP:     write_reg(ins[11:7], ref_alu(f3, ins[30], a, b));
            rv_core_pkg::OPC_OP_IMM: write_reg(ins[11:7],
                                               ref_alu(f3, ins[30] && (f3 == 3'b101), a, imm_i));
            rv_core_pkg::OPC_LUI:    write_reg(ins[11:7], {ins[31:12], 12'h000});
            rv_core_pkg::OPC_LOAD: begin
                addr = a + imm_i;
                word = ref_mem[addr[7:2]];
                exp_load_addr.push_back(addr);
                case (f3)
                    rv_core_pkg::F3_B:  word = {{24{word[7]}}, word[7:0]};
                    rv_core_pkg::F3_H:  word = {{16{word[15]}}, word[15:0]};
                    rv_core_pkg::F3_BU: word = {24'h0, word[7:0]};
                    rv_core_pkg::F3_HU: word = {16'h0, word[15:0]};
                    default:            word = word;
                endcase
                write_reg(ins[11:7], word);
            end
            rv_core_pkg::OPC_STORE: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (f3 == rv_core_pkg::F3_B) begin
                    word = {24'h0, b[7:0]};
                end else if (f3 == rv_core_pkg::F3_H) begin
                    word = {16'h0, b[15:0]};
                end else begin
                    word = b;
                end
                ref_mem[addr[7:2]] = word;
                exp_store_addr.push_back(addr);
                exp_store_data.push_back(word);
            end
            default: ;
        endcase
    end
endtask

`endif

// ==== tb/tb_rv_core.sv ====
/* Testbench for the RV32I core: random program, instruction and data
   memory models, store and load checking against the reference model */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int          PROG_LEN       = 96;
    localparam int          DMEM_WORDS     = 64;
    localparam int          MAX_LOAD_WAIT  = 3;
    localparam int          MAX_FETCH_WAIT = 2;
    localparam logic [31:0] SEED           = 32'hb931f5ba;
    localparam int          CYCLE_LIMIT    = PROG_LEN * 8 + 50;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_if_valid;
    logic        i_mem_valid;
    logic [31:0] i_instr;
    logic [31:0] i_mem_rdata;
    wire  [31:0] o_pc;
    wire  [31:0] o_mem_addr;
    wire  [31:0] o_mem_wdata;
    wire         o_load_req;
    wire         o_store_req;

    logic [31:0] prog [0:PROG_LEN-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] exp_store_addr [$];
    logic [31:0] exp_store_data [$];
    logic [31:0] exp_load_addr [$];
    logic [31:0] lfsr      = SEED;
    int          errors    = 0;
    int          cycles    = 0;
    int          fetch_gap = 0;
    int          load_wait = 0;

    `include "rv_iss.svh"

    rv_core u_rv_core (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_if_valid  (i_if_valid),
        .i_instr     (i_instr),
        .o_pc        (o_pc),
        .o_load_req  (o_load_req),
        .o_store_req (o_store_req),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .i_mem_valid (i_mem_valid),
        .i_mem_rdata (i_mem_rdata)
    );

    // Zero-latency instruction store, NOPs past the program
    assign i_instr     = (o_pc[31:2] < PROG_LEN) ? prog[o_pc[31:2]] : rv_core_pkg::NOP;
    assign i_mem_rdata = dmem[o_mem_addr[7:2]];

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = 32'd0;
        for (int k = 0; k < n; k++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    function automatic logic [2:0] load_size(input logic [2:0] pick);
        case (pick)
            3'd0, 3'd5: return rv_core_pkg::F3_B;
            3'd1, 3'd6: return rv_core_pkg::F3_H;
            3'd2, 3'd7: return rv_core_pkg::F3_W;
            3'd3:       return rv_core_pkg::F3_BU;
            default:    return rv_core_pkg::F3_HU;
        endcase
    endfunction

    // Registers x0..x7 only, memory accesses based on x0
    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [7:0]  off;
        rd  = 5'(take_bits(3));
        rs1 = 5'(take_bits(3));
        rs2 = 5'(take_bits(3));
        f3  = 3'(take_bits(3));
        alt = ((f3 == 3'b000) || (f3 == 3'b101)) ? 1'(take_bits(1)) : 1'b0;
        off = 8'(take_bits(8));
        case (3'(take_bits(3)))
            3'd0, 3'd1: return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
            3'd2, 3'd3: begin
                // Shift immediates carry shamt and the SRAI bit only
                if ((f3 == 3'b001) || (f3 == 3'b101)) begin
                    imm = {1'b0, alt, 5'b0, 5'(take_bits(5))};
                end else begin
                    imm = 12'(take_bits(12));
                end
                return {imm, rs1, f3, rd, rv_core_pkg::OPC_OP_IMM};
            end
            3'd4:       return {20'(take_bits(20)), rd, rv_core_pkg::OPC_LUI};
            3'd5, 3'd7: return {4'b0, off, 5'd0, load_size(f3), rd, rv_core_pkg::OPC_LOAD};
            default: begin
                f3 = (f3[1:0] == 2'd0) ? rv_core_pkg::F3_B :
                     (f3[1:0] == 2'd1) ? rv_core_pkg::F3_H : rv_core_pkg::F3_W;
                return {4'b0, off[7:5], rs2, 5'd0, f3, off[4:0], rv_core_pkg::OPC_STORE};
            end
        endcase
    endfunction

    // Set up x1..x7, random body, then dump x1..x7 to words 56..62
    task automatic build_program();
        for (int r = 1; r < 8; r++) begin
            prog[2*r-2] = {20'(take_bits(20)), 5'(r), rv_core_pkg::OPC_LUI};
            prog[2*r-1] = {12'(take_bits(12)), 5'(r), 3'b000, 5'(r), rv_core_pkg::OPC_OP_IMM};
        end
        for (int i = 14; i < PROG_LEN - 7; i++) begin
            prog[i] = random_instr();
        end
        for (int r = 1; r < 8; r++) begin
            prog[PROG_LEN-8+r] = {7'd7, 5'(r), 5'd0, rv_core_pkg::F3_W, 5'(4*r-4),
                                  rv_core_pkg::OPC_STORE};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d, stores left: %0d, loads left: %0d",
                 errors, exp_store_addr.size(), exp_load_addr.size());
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // Fetch valid drops and load delays, the only LFSR users after time 0
    always @(posedge i_clk) begin
        if ((fetch_gap < MAX_FETCH_WAIT) && (take_bits(2) == 32'd0)) begin
            i_if_valid <= 1'b0;
            fetch_gap  <= fetch_gap + 1;
        end else begin
            i_if_valid <= 1'b1;
            fetch_gap  <= 0;
        end
        // Delay counts cycles with a request pending
        if (o_load_req === 1'b1) begin
            if (i_mem_valid) begin
                load_wait = int'(take_bits(2)) % (MAX_LOAD_WAIT + 1);
            end else begin
                load_wait = load_wait - 1;
            end
            i_mem_valid <= (load_wait == 0);
        end
    end

    // Word memory and in-order request checks
    always @(posedge i_clk) begin
        if (i_rst_n === 1'b1) begin
            if (o_store_req === 1'b1) begin
                if (exp_store_addr.size() == 0) begin
                    $display("Error: store to %h that the reference never made", o_mem_addr);
                    errors++;
                end else begin
                    check_value("store address", exp_store_addr.pop_front(), o_mem_addr);
                    check_value("store data", exp_store_data.pop_front(), o_mem_wdata);
                end
                dmem[o_mem_addr[7:2]] <= o_mem_wdata;
            end
            if ((o_load_req === 1'b1) && (i_mem_valid === 1'b1)) begin
                if (exp_load_addr.size() == 0) begin
                    $display("Error: load from %h that the reference never made", o_mem_addr);
                    errors++;
                end else begin
                    check_value("load address", exp_load_addr.pop_front(), o_mem_addr);
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Error: timeout, the core stopped before all stores and loads came out");
            errors++;
            finish_run();
        end
    end

    initial begin
        i_rst_n     = 1'b0;
        i_if_valid  = 1'b0;
        i_mem_valid = 1'b0;
        build_program();
        run_reference();
        for (int w = 0; w < DMEM_WORDS; w++) begin
            dmem[w] = fill_word(w);
        end
        load_wait   = int'(take_bits(2)) % (MAX_LOAD_WAIT + 1);
        i_mem_valid = (load_wait == 0);
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_value("reset pc", rv_core_pkg::PC_START, o_pc);
        check_value("reset load request", 32'd0, {31'd0, o_load_req});
        check_value("reset store request", 32'd0, {31'd0, o_store_req});
        while ((exp_store_addr.size() != 0) || (exp_load_addr.size() != 0)) begin
            @(posedge i_clk);
        end
        // Trailing NOPs, any extra request shows up here
        repeat (10) @(posedge i_clk);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tb
verilog/rv_core_pkg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_hazard.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
tb/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - verilog/rv_core_pkg.sv
  - verilog/rv_decode.sv
  - verilog/rv_regfile.sv
  - verilog/rv_alu.sv
  - verilog/rv_hazard.sv
  - verilog/rv_lsu.sv
  - verilog/rv_core.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_rv_core.sv
